//--- sources.f
+incdir+bench
src/core_pkg.sv
src/core_bus_if.sv
src/fetch.sv
src/decode.sv
src/execute.sv
src/lsu.sv
src/nox_core.sv
bench/tb_nox_core.sv

//--- bench/tb_model.svh
// Included inside tb_nox_core only; programs use x0-based word addresses below 4 KiB and forward jumps
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int O_ADD = 0;
localparam int O_SUB = 1;
localparam int O_AND = 2;
localparam int O_OR  = 3;
localparam int O_XOR = 4;
localparam int O_SLT = 5;
localparam int O_LUI = 6;
localparam int O_BEQ = 7;
localparam int O_BNE = 8;
localparam int O_JAL = 9;
localparam int O_LW  = 10;
localparam int O_SW  = 11;
localparam logic [31:0] NOP_WORD = 32'h0000_0013;

logic [31:0] seed_q = 32'h255f18ac;
logic [31:0] imem [0:1023];
logic [31:0] mmem [0:1023];
int          m_op [0:1023];
bit          m_ui [0:1023];
int          m_rd [0:1023];
int          m_rs1 [0:1023];
int          m_rs2 [0:1023];
int          m_imm [0:1023];
int          prog_len;
logic [31:0] exp_addr [0:1023];
logic [31:0] exp_data [0:1023];
int          exp_n;

function automatic logic [31:0] xorshift(input logic [31:0] s);
  logic [31:0] x;
  x = s ^ (s << 13);
  x = x ^ (x >> 17);
  return x ^ (x << 5);
endfunction

function logic [31:0] rand_next();
  seed_q = xorshift(seed_q);
  return seed_q;
endfunction

function int pick_reg();
  return rand_next() % 32;
endfunction

// Initial data memory contents, every address bit matters
function automatic logic [31:0] fill_word(input logic [31:0] addr);
  return (addr * 32'h9e37_79b1) ^ 32'h3c6e_f372;
endfunction

// Encode one instruction and keep its fields for the model
task automatic emit(input int op, input bit ui, input int rd, input int rs1, input int rs2,
                    input int imm);
  logic [31:0] w;
  logic [2:0]  f3;
  case (op)
    O_AND:   f3 = 3'b111;
    O_OR:    f3 = 3'b110;
    O_XOR:   f3 = 3'b100;
    O_SLT:   f3 = 3'b010;
    default: f3 = 3'b000;
  endcase
  case (op)
    O_LUI: w = {imm[19:0], rd[4:0], 7'b0110111};
    O_JAL: w = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    O_BEQ, O_BNE: begin
      w = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 2'b00, op == O_BNE,
           imm[4:1], imm[11], 7'b1100011};
    end
    O_LW: w = {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    O_SW: w = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    default: begin
      if (ui) begin
        w = {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0010011};
      end else begin
        w = {(op == O_SUB) ? 7'b0100000 : 7'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
      end
    end
  endcase
  imem[prog_len]  = w;
  m_op[prog_len]  = op;
  m_ui[prog_len]  = ui;
  m_rd[prog_len]  = rd;
  m_rs1[prog_len] = rs1;
  m_rs2[prog_len] = rs2;
  m_imm[prog_len] = imm;
  prog_len++;
endtask

task automatic emit_alu();
  logic [31:0] r;
  int          op;
  r  = rand_next();
  op = r % 7;
  if (op == O_LUI) begin
    emit(O_LUI, 0, r[7:3], 0, 0, r[31:12]);
  end else begin
    emit(op, (op != O_SUB) && r[8], r[7:3], r[13:9], r[18:14], $signed(r[31:20]));
  end
endtask

// Forward targets 8 to 16 bytes ahead
task automatic emit_branch();
  logic [31:0] r;
  int          rs1;
  r   = rand_next();
  rs1 = r[4:0];
  if (r[9:8] == 0) begin
    emit(O_JAL, 0, r[14:10], 0, 0, 8 + 4 * (r[6:5] % 3));
  end else begin
    emit((r[9:8] == 1) ? O_BEQ : O_BNE, 0, 0, rs1, r[7] ? rs1 : r[14:10],
         8 + 4 * (r[6:5] % 3));
  end
endtask

task automatic gen_program(input int kind);
  logic [31:0] r;
  int          rd;
  int          i;
  prog_len = 0;
  for (i = 0; i < 1024; i++) begin
    imem[i] = NOP_WORD;
  end
  if (kind != 1) begin
    // Every register gets a known value before use
    for (i = 1; i < 32; i++) begin
      r = rand_next();
      emit(O_LUI, 0, i, 0, 0, r[19:0]);
    end
    for (i = 0; i < 40; i++) begin
      r = rand_next();
      if (kind == 3 && r[1:0] == 0) begin
        emit_branch();
      end else if (kind == 4 && r[1:0] == 1) begin
        rd = 1 + rand_next() % 31;
        emit(O_LW, 0, rd, 0, 0, 256 + 4 * r[5:2]);
        // Consumer right behind the load
        emit(O_ADD, 0, pick_reg(), rd, pick_reg(), 0);
      end else if (kind == 4 && r[1:0] == 2) begin
        emit(O_SW, 0, 0, 0, pick_reg(), 256 + 4 * r[5:2]);
      end else begin
        emit_alu();
      end
    end
    // Register dump, x0 included
    for (i = 0; i < 32; i++) begin
      emit(O_SW, 0, 0, 0, i, 512 + 4 * i);
    end
  end
  emit(O_JAL, 0, 0, 0, 0, 0);
endtask

// Architectural run up to the final self jump, collecting the stores
task automatic run_model();
  logic [31:0] rf [0:31];
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] res;
  logic [31:0] addr;
  int          pc;
  int          nxt;
  int          i;
  for (i = 0; i < 32; i++) begin
    rf[i] = '0;
  end
  for (i = 0; i < 1024; i++) begin
    mmem[i] = fill_word(i * 4);
  end
  pc    = 0;
  exp_n = 0;
  while (!(m_op[pc] == O_JAL && m_imm[pc] == 0)) begin
    a    = rf[m_rs1[pc]];
    b    = m_ui[pc] ? m_imm[pc] : rf[m_rs2[pc]];
    addr = (a + m_imm[pc]) & ~32'd3;
    nxt  = pc + 1;
    res  = '0;
    case (m_op[pc])
      O_ADD: res = a + b;
      O_SUB: res = a - b;
      O_AND: res = a & b;
      O_OR:  res = a | b;
      O_XOR: res = a ^ b;
      O_SLT: res = {31'b0, $signed(a) < $signed(b)};
      O_LUI: res = m_imm[pc] << 12;
      O_JAL: res = pc * 4 + 4;
      O_LW:  res = mmem[addr[11:2]];
      O_SW: begin
        exp_addr[exp_n]  = addr;
        exp_data[exp_n]  = b;
        mmem[addr[11:2]] = b;
        exp_n++;
      end
      default: res = '0;
    endcase
    if ((m_op[pc] == O_BEQ && a == b) || (m_op[pc] == O_BNE && a != b) || m_op[pc] == O_JAL) begin
      nxt = pc + m_imm[pc] / 4;
    end
    if ((m_op[pc] <= O_LUI || m_op[pc] == O_JAL || m_op[pc] == O_LW) && m_rd[pc] != 0) begin
      rf[m_rd[pc]] = res;
    end
    pc = nxt;
  end
endtask

`endif

//--- bench/tb_nox_core.sv
// Random programs from a fixed seed; the store stream on the data bus is compared in order
`timescale 1ns/1ps

module tb_nox_core;
  logic        clk;
  logic        rst_n_i;
  logic        instr_req_valid_o;
  logic        instr_req_ready_i;
  logic [31:0] instr_addr_o;
  logic        instr_rsp_valid_i;
  logic [31:0] instr_rdata_i;
  logic        data_req_valid_o;
  logic        data_req_ready_i;
  logic [31:0] data_addr_o;
  logic        data_we_o;
  logic [31:0] data_wdata_o;
  logic        data_rsp_valid_i;
  logic [31:0] data_rdata_i;

  logic [31:0] dmem [0:1023];
  logic [31:0] i_addr;
  logic [31:0] d_rdata;
  bit          heavy;
  bit          i_pend;
  bit          d_pend;
  int          i_wait;
  int          d_wait;
  int          errors;
  int          obs_n;
  int          cycles;
  int          limit;
  int          passed;
  int          failed;

  `include "tb_model.svh"

  nox_core nox_core_inst (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .instr_req_valid_o (instr_req_valid_o),
    .instr_req_ready_i (instr_req_ready_i),
    .instr_addr_o      (instr_addr_o),
    .instr_rsp_valid_i (instr_rsp_valid_i),
    .instr_rdata_i     (instr_rdata_i),
    .data_req_valid_o  (data_req_valid_o),
    .data_req_ready_i  (data_req_ready_i),
    .data_addr_o       (data_addr_o),
    .data_we_o         (data_we_o),
    .data_wdata_o      (data_wdata_o),
    .data_rsp_valid_i  (data_rsp_valid_i),
    .data_rdata_i      (data_rdata_i)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %08h expected %08h", name, got, exp);
      errors++;
    end
  endtask

  // Heavy mode gives ready one cycle in four and longer responses
  function logic pick_ready();
    return heavy ? (rand_next() % 4 == 0) : (rand_next() % 4 != 0);
  endfunction

  function int pick_delay();
    return heavy ? 4 + rand_next() % 5 : rand_next() % 4;
  endfunction

  task automatic record_store(input logic [31:0] addr, input logic [31:0] data);
    if (obs_n >= exp_n) begin
      $display("unexpected store of %08h to %08h after the expected %0d stores", data, addr, exp_n);
      errors++;
    end else begin
      check_value("data_addr_o", addr, exp_addr[obs_n]);
      check_value("data_wdata_o", data, exp_data[obs_n]);
    end
    obs_n++;
  endtask

  // Instruction memory responder
  always @(posedge clk) begin
    if (!rst_n_i) begin
      instr_req_ready_i <= 1'b0;
      instr_rsp_valid_i <= 1'b0;
      i_pend = 1'b0;
    end else begin
      instr_rsp_valid_i <= 1'b0;
      if (i_pend && i_wait == 0) begin
        instr_rsp_valid_i <= 1'b1;
        instr_rdata_i     <= imem[i_addr[11:2]];
        i_pend = 1'b0;
      end else if (i_pend) begin
        i_wait = i_wait - 1;
      end
      if (instr_req_valid_o && instr_req_ready_i) begin
        i_pend = 1'b1;
        i_addr = instr_addr_o;
        i_wait = pick_delay();
      end
      instr_req_ready_i <= pick_ready();
    end
  end

  // Data memory responder that checks stores on acceptance
  always @(posedge clk) begin
    if (!rst_n_i) begin
      data_req_ready_i <= 1'b0;
      data_rsp_valid_i <= 1'b0;
      d_pend = 1'b0;
    end else begin
      data_rsp_valid_i <= 1'b0;
      if (d_pend && d_wait == 0) begin
        data_rsp_valid_i <= 1'b1;
        data_rdata_i     <= d_rdata;
        d_pend = 1'b0;
      end else if (d_pend) begin
        d_wait = d_wait - 1;
      end
      if (data_req_valid_o && data_req_ready_i) begin
        d_pend  = 1'b1;
        d_wait  = pick_delay();
        d_rdata = dmem[data_addr_o[11:2]];
        if (data_we_o) begin
          dmem[data_addr_o[11:2]] = data_wdata_o;
          record_store(data_addr_o, data_wdata_o);
        end
      end
      data_req_ready_i <= pick_ready();
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout: the core stopped making progress after %0d cycles", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Kind 5 reruns the kind 4 program
  task automatic run_test(input int kind, input bit slow, input string name);
    int errs_before;
    int i;
    errs_before = errors;
    @(posedge clk);
    rst_n_i <= 1'b0;
    @(posedge clk);
    heavy = slow;
    if (kind != 5) begin
      gen_program(kind);
      run_model();
    end
    for (i = 0; i < 1024; i++) begin
      dmem[i] = fill_word(i * 4);
    end
    obs_n = 0;
    limit = limit + 40 * prog_len;
    repeat (4) begin
      @(negedge clk);
      if (kind == 1) begin
        check_value("data_req_valid_o", data_req_valid_o, 32'h0);
        check_value("instr_req_valid_o", instr_req_valid_o, 32'h0);
      end
    end
    @(posedge clk);
    rst_n_i <= 1'b1;
    if (kind == 1) begin
      @(negedge clk);
      while (!(instr_req_valid_o && instr_req_ready_i)) begin
        @(negedge clk);
      end
      check_value("instr_addr_o", instr_addr_o, 32'h0);
    end
    while (obs_n < exp_n) begin
      @(posedge clk);
    end
    // Room for a duplicated store to show up
    repeat (20) @(posedge clk);
    if (errors == errs_before) begin
      passed++;
      $display("test %0d %s: ok, %0d stores", kind, name, obs_n);
    end else begin
      failed++;
      $display("test %0d %s: %0d errors", kind, name, errors - errs_before);
    end
  endtask

  initial begin
    rst_n_i           = 1'b0;
    instr_req_ready_i = 1'b0;
    instr_rsp_valid_i = 1'b0;
    instr_rdata_i     = '0;
    data_req_ready_i  = 1'b0;
    data_rsp_valid_i  = 1'b0;
    data_rdata_i      = '0;
    heavy             = 1'b0;
    errors            = 0;
    cycles            = 0;
    limit             = 200;
    passed            = 0;
    failed            = 0;
    run_test(1, 0, "reset and first fetch");
    run_test(2, 0, "alu, immediate and lui");
    run_test(3, 0, "branches and jal");
    run_test(4, 0, "loads, stores and load-use");
    run_test(5, 1, "heavy back-pressure");
    $display("tests passed %0d failed %0d", passed, failed);
    if (failed == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end
endmodule

//--- src/nox_core.sv
// Both buses must return exactly one in-order response per accepted request
`timescale 1ns/1ps

module nox_core (
  input  logic                      clk,
  input  logic                      rst_n_i,
  // Instruction bus
  output logic                      instr_req_valid_o,
  input  logic                      instr_req_ready_i,
  output core_pkg::pc_t             instr_addr_o,
  input  logic                      instr_rsp_valid_i,
  input  logic [core_pkg::XLEN-1:0] instr_rdata_i,
  // Data bus
  output logic                      data_req_valid_o,
  input  logic                      data_req_ready_i,
  output core_pkg::pc_t             data_addr_o,
  output logic                      data_we_o,
  output logic [core_pkg::XLEN-1:0] data_wdata_o,
  input  logic                      data_rsp_valid_i,
  input  logic [core_pkg::XLEN-1:0] data_rdata_i
);
  import core_pkg::*;

  logic            fetch_valid;
  logic            fetch_ready;
  logic [XLEN-1:0] fetch_instr;
  pc_t             fetch_pc;
  logic            id_valid;
  logic            id_ready;
  id_ex_t          id_ex;
  logic            redirect_valid;
  pc_t             redirect_pc;
  logic            lsu_valid;
  logic            lsu_ready;
  lsu_req_t        lsu_req;
  wb_t             alu_wb;
  wb_t             lsu_wb;
  busy_rd_t        lsu_busy_rd;

  core_bus_if instr_bus ();
  core_bus_if data_bus ();

  // Instruction fetch is read-only, so we and wdata stay inside
  assign instr_req_valid_o   = instr_bus.req_valid;
  assign instr_addr_o        = instr_bus.addr;
  assign instr_bus.req_ready = instr_req_ready_i;
  assign instr_bus.rsp_valid = instr_rsp_valid_i;
  assign instr_bus.rdata     = instr_rdata_i;

  assign data_req_valid_o   = data_bus.req_valid;
  assign data_addr_o        = data_bus.addr;
  assign data_we_o          = data_bus.we;
  assign data_wdata_o       = data_bus.wdata;
  assign data_bus.req_ready = data_req_ready_i;
  assign data_bus.rsp_valid = data_rsp_valid_i;
  assign data_bus.rdata     = data_rdata_i;

  fetch u_fetch (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .bus_o            (instr_bus.master),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .fetch_valid_o    (fetch_valid),
    .fetch_ready_i    (fetch_ready),
    .instr_o          (fetch_instr),
    .pc_o             (fetch_pc)
  );

  decode u_decode (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .fetch_valid_i    (fetch_valid),
    .fetch_ready_o    (fetch_ready),
    .instr_i          (fetch_instr),
    .pc_i             (fetch_pc),
    .flush_i          (redirect_valid),
    .alu_wb_i         (alu_wb),
    .lsu_wb_i         (lsu_wb),
    .lsu_busy_rd_i    (lsu_busy_rd),
    .id_valid_o       (id_valid),
    .id_ready_i       (id_ready),
    .id_ex_o          (id_ex)
  );

  execute u_execute (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .id_valid_i       (id_valid),
    .id_ready_o       (id_ready),
    .id_ex_i          (id_ex),
    .lsu_wb_active_i  (lsu_wb.we),
    .alu_wb_o         (alu_wb),
    .redirect_valid_o (redirect_valid),
    .redirect_pc_o    (redirect_pc),
    .lsu_valid_o      (lsu_valid),
    .lsu_ready_i      (lsu_ready),
    .lsu_req_o        (lsu_req)
  );

  lsu u_lsu (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .lsu_valid_i      (lsu_valid),
    .lsu_ready_o      (lsu_ready),
    .lsu_req_i        (lsu_req),
    .bus_o            (data_bus.master),
    .lsu_wb_o         (lsu_wb),
    .lsu_busy_rd_o    (lsu_busy_rd)
  );
endmodule

//--- src/lsu.sv
// One memory op at a time; stores also wait for their bus response before the next op
`timescale 1ns/1ps

module lsu (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                lsu_valid_i,
  output logic                lsu_ready_o,
  input  core_pkg::lsu_req_t  lsu_req_i,
  core_bus_if.master          bus_o,
  output core_pkg::wb_t       lsu_wb_o,
  output core_pkg::busy_rd_t  lsu_busy_rd_o
);
  import core_pkg::*;

  lsu_req_t req_q;
  logic     busy_q;
  logic     pend_q;
  logic     take;
  logic     rsp_done;

  assign lsu_ready_o = !busy_q;
  assign take        = lsu_valid_i && lsu_ready_o;
  // Response only counts once the request has gone out
  assign rsp_done    = busy_q && !pend_q && bus_o.rsp_valid;

  assign bus_o.req_valid = pend_q;
  assign bus_o.addr      = req_q.addr;
  assign bus_o.we        = req_q.is_store;
  assign bus_o.wdata     = req_q.wdata;

  assign lsu_wb_o.we   = rsp_done && !req_q.is_store;
  assign lsu_wb_o.rd   = req_q.rd;
  assign lsu_wb_o.data = bus_o.rdata;

  assign lsu_busy_rd_o.valid = busy_q && !req_q.is_store;
  assign lsu_busy_rd_o.rd    = req_q.rd;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      pend_q <= 1'b0;
    end else if (take) begin
      busy_q <= 1'b1;
      pend_q <= 1'b1;
    end else begin
      if (bus_o.req_valid && bus_o.req_ready) begin
        pend_q <= 1'b0;
      end
      if (rsp_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      req_q <= lsu_req_i;
    end
  end
endmodule

//--- src/execute.sv
// Results are written on acceptance; a taken jump costs one bubble while the redirect is raised
`timescale 1ns/1ps

module execute (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                id_valid_i,
  output logic                id_ready_o,
  input  core_pkg::id_ex_t    id_ex_i,
  input  logic                lsu_wb_active_i,
  output core_pkg::wb_t       alu_wb_o,
  output logic                redirect_valid_o,
  output core_pkg::pc_t       redirect_pc_o,
  output logic                lsu_valid_o,
  input  logic                lsu_ready_i,
  output core_pkg::lsu_req_t  lsu_req_o
);
  import core_pkg::*;

  logic [XLEN-1:0] opb;
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] result;
  logic            is_mem;
  logic            writes_rd;
  logic            taken;
  logic            accept;

  assign opb = id_ex_i.imm_sel ? id_ex_i.imm : id_ex_i.rs2_val;
  assign sum = id_ex_i.rs1_val + opb;

  always_comb begin
    case (id_ex_i.op)
      SUB:     result = id_ex_i.rs1_val - opb;
      AND:     result = id_ex_i.rs1_val & opb;
      OR:      result = id_ex_i.rs1_val | opb;
      XOR:     result = id_ex_i.rs1_val ^ opb;
      SLT:     result = {{(XLEN-1){1'b0}}, $signed(id_ex_i.rs1_val) < $signed(opb)};
      LUI:     result = id_ex_i.imm;
      JAL:     result = id_ex_i.pc + 'd4;
      default: result = sum;
    endcase
  end

  assign writes_rd = id_ex_i.op inside {ADD, SUB, AND, OR, XOR, SLT, LUI, JAL};
  assign is_mem    = id_ex_i.op inside {LW, SW};
  assign taken     = ((id_ex_i.op == BEQ) && (id_ex_i.rs1_val == id_ex_i.rs2_val)) ||
                     ((id_ex_i.op == BNE) && (id_ex_i.rs1_val != id_ex_i.rs2_val)) ||
                     (id_ex_i.op == JAL);

  // Hold off during a redirect, the decode content is wrong-path
  // Lsu owns the write port when it writes back
  assign id_ready_o = !redirect_valid_o &&
                      (is_mem ? lsu_ready_i : !(writes_rd && lsu_wb_active_i));
  assign accept     = id_valid_i && id_ready_o;

  assign alu_wb_o.we   = accept && writes_rd;
  assign alu_wb_o.rd   = id_ex_i.rd;
  assign alu_wb_o.data = result;

  assign lsu_valid_o        = id_valid_i && is_mem && !redirect_valid_o;
  assign lsu_req_o.is_store = (id_ex_i.op == SW);
  assign lsu_req_o.addr     = {sum[XLEN-1:2], 2'b00};
  assign lsu_req_o.wdata    = id_ex_i.rs2_val;
  assign lsu_req_o.rd       = id_ex_i.rd;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      redirect_valid_o <= 1'b0;
    end else begin
      redirect_valid_o <= accept && taken;
    end
  end

  // Branch and JAL targets are both pc relative
  always_ff @(posedge clk) begin
    if (accept) begin
      redirect_pc_o <= id_ex_i.pc + id_ex_i.imm;
    end
  end
endmodule

//--- src/decode.sv
// Source hazards are checked on both rs fields, so some instructions wait longer than needed
`timescale 1ns/1ps

module decode (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      fetch_valid_i,
  output logic                      fetch_ready_o,
  input  logic [core_pkg::XLEN-1:0] instr_i,
  input  core_pkg::pc_t             pc_i,
  input  logic                      flush_i,
  input  core_pkg::wb_t             alu_wb_i,
  input  core_pkg::wb_t             lsu_wb_i,
  input  core_pkg::busy_rd_t        lsu_busy_rd_i,
  output logic                      id_valid_o,
  input  logic                      id_ready_i,
  output core_pkg::id_ex_t          id_ex_o
);
  import core_pkg::*;

  logic [XLEN-1:0] regs [32];
  id_ex_t          dec;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  reg_idx_t        rs1;
  reg_idx_t        rs2;
  logic            hold;
  logic            accept;

  // Register read with same-cycle write forwarding
  function automatic logic [XLEN-1:0] read_reg(input reg_idx_t idx);
    if (idx == '0) return '0;
    if (lsu_wb_i.we && (lsu_wb_i.rd == idx)) return lsu_wb_i.data;
    if (alu_wb_i.we && (alu_wb_i.rd == idx)) return alu_wb_i.data;
    return regs[idx];
  endfunction

  // Load pending in lsu or waiting here to leave for execute
  function automatic logic pending(input reg_idx_t idx);
    logic in_lsu;
    logic in_dec;
    in_lsu = lsu_busy_rd_i.valid && (lsu_busy_rd_i.rd == idx);
    in_dec = id_valid_o && (id_ex_o.op == LW) && (id_ex_o.rd == idx);
    return (idx != '0) && (in_lsu || in_dec);
  endfunction

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];

  always_comb begin
    dec         = '0;
    dec.op      = NOP;
    dec.pc      = pc_i;
    dec.rd      = instr_i[11:7];
    dec.rs1_val = read_reg(rs1);
    dec.rs2_val = read_reg(rs2);
    case (opcode)
      7'b0110011, 7'b0010011: begin
        dec.imm     = {{20{instr_i[31]}}, instr_i[31:20]};
        dec.imm_sel = !opcode[5];
        case (funct3)
          3'b000:  dec.op = (opcode[5] && instr_i[30]) ? SUB : ADD;
          3'b010:  dec.op = SLT;
          3'b100:  dec.op = XOR;
          3'b110:  dec.op = OR;
          3'b111:  dec.op = AND;
          default: dec.op = NOP;
        endcase
        // Register form only allows funct7 zero, or SUB
        if (opcode[5] && (instr_i[31:25] != 7'b0) &&
            !((instr_i[31:25] == 7'b0100000) && (funct3 == 3'b000))) begin
          dec.op = NOP;
        end
      end
      7'b0110111: begin
        dec.op  = LUI;
        dec.imm = {instr_i[31:12], 12'b0};
      end
      7'b1100011: begin
        dec.imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
        if (funct3 == 3'b000) dec.op = BEQ;
        else if (funct3 == 3'b001) dec.op = BNE;
      end
      7'b1101111: begin
        dec.op  = JAL;
        dec.imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
      end
      7'b0000011: begin
        dec.imm     = {{20{instr_i[31]}}, instr_i[31:20]};
        dec.imm_sel = 1'b1;
        if (funct3 == 3'b010) dec.op = LW;
      end
      7'b0100011: begin
        dec.imm     = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
        dec.imm_sel = 1'b1;
        if (funct3 == 3'b010) dec.op = SW;
      end
      default: dec.op = NOP;
    endcase
  end

  always_comb begin
    hold = pending(rs1) || pending(rs2);
  end

  assign fetch_ready_o = (!id_valid_o || id_ready_i) && !hold;
  assign accept        = fetch_valid_i && fetch_ready_o && !flush_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      id_valid_o <= 1'b0;
    end else if (flush_i) begin
      id_valid_o <= 1'b0;
    end else if (accept) begin
      id_valid_o <= 1'b1;
    end else if (id_ready_i) begin
      id_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      id_ex_o <= dec;
    end
  end

  // Lsu wins the single write port
  always_ff @(posedge clk) begin
    if (lsu_wb_i.we && (lsu_wb_i.rd != '0)) begin
      regs[lsu_wb_i.rd] <= lsu_wb_i.data;
    end else if (alu_wb_i.we && (alu_wb_i.rd != '0)) begin
      regs[alu_wb_i.rd] <= alu_wb_i.data;
    end
  end
endmodule

//--- src/fetch.sv
// Fetches from address 0 after reset; a request is only issued once the output buffer is free
`timescale 1ns/1ps

module fetch (
  input  logic                      clk,
  input  logic                      rst_n_i,
  core_bus_if.master                bus_o,
  input  logic                      redirect_valid_i,
  input  core_pkg::pc_t             redirect_pc_i,
  output logic                      fetch_valid_o,
  input  logic                      fetch_ready_i,
  output logic [core_pkg::XLEN-1:0] instr_o,
  output core_pkg::pc_t             pc_o
);
  import core_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT
  } state_e;

  state_e state_q;
  pc_t    pc_q;
  pc_t    addr_q;
  logic   discard_q;
  logic   issue;
  logic   accepted;
  logic   rsp_seen;

  // Response always has a free slot since only one request is in flight
  // No request goes out while reset is held
  assign issue    = rst_n_i && (state_q == ST_IDLE) && (!fetch_valid_o || fetch_ready_i) &&
                    !redirect_valid_i;
  assign accepted = bus_o.req_valid && bus_o.req_ready;
  assign rsp_seen = (state_q == ST_WAIT) && bus_o.rsp_valid;

  assign bus_o.req_valid = issue || (state_q == ST_REQ);
  assign bus_o.addr      = (state_q == ST_IDLE) ? pc_q : addr_q;
  assign bus_o.we        = 1'b0;
  assign bus_o.wdata     = '0;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      pc_q      <= '0;
      discard_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: if (issue) state_q <= accepted ? ST_WAIT : ST_REQ;
        ST_REQ:  if (accepted) state_q <= ST_WAIT;
        ST_WAIT: if (bus_o.rsp_valid) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
      if (redirect_valid_i) begin
        pc_q <= redirect_pc_i;
      end else if (issue) begin
        pc_q <= pc_q + 'd4;
      end
      // Request already on the bus belongs to the old path
      if (rsp_seen) begin
        discard_q <= 1'b0;
      end else if (redirect_valid_i && (state_q != ST_IDLE)) begin
        discard_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      fetch_valid_o <= 1'b0;
    end else if (redirect_valid_i) begin
      fetch_valid_o <= 1'b0;
    end else if (rsp_seen && !discard_q) begin
      fetch_valid_o <= 1'b1;
    end else if (fetch_ready_i) begin
      fetch_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      addr_q <= pc_q;
    end
    if (rsp_seen) begin
      instr_o <= bus_o.rdata;
      pc_o    <= addr_q;
    end
  end
endmodule

//--- src/core_bus_if.sv
// One request and one in-order response per transfer; master keeps at most one outstanding
`timescale 1ns/1ps

interface core_bus_if;
  import core_pkg::*;

  // Request channel
  logic            req_valid;
  logic            req_ready;
  logic [XLEN-1:0] addr;
  logic            we;
  logic [XLEN-1:0] wdata;

  // Response channel, never back-pressured
  logic            rsp_valid;
  logic [XLEN-1:0] rdata;

  modport master (
    output req_valid, addr, we, wdata,
    input  req_ready, rsp_valid, rdata
  );

  modport slave (
    input  req_valid, addr, we, wdata,
    output req_ready, rsp_valid, rdata
  );
endinterface

//--- src/core_pkg.sv
// RV32I subset only: word accesses, no CSRs or traps, unsupported encodings decode to NOP
package core_pkg;

  // Data and address width
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] pc_t;
  typedef logic [4:0]      reg_idx_t;

  // Decoded operations, NOP covers every unsupported encoding
  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    LUI,
    BEQ,
    BNE,
    JAL,
    LW,
    SW,
    NOP
  } op_e;

  // Decode to execute payload
  typedef struct packed {
    op_e             op;
    pc_t             pc;
    reg_idx_t        rd;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] imm;
    logic            imm_sel;
  } id_ex_t;

  // Register file write
  typedef struct packed {
    logic            we;
    reg_idx_t        rd;
    logic [XLEN-1:0] data;
  } wb_t;

  // Memory op from execute to lsu, address already word aligned
  typedef struct packed {
    logic            is_store;
    pc_t             addr;
    logic [XLEN-1:0] wdata;
    reg_idx_t        rd;
  } lsu_req_t;

  // Destination of a load still in flight
  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
  } busy_rd_t;

endpackage
